//--- Bender.yml
package:
  name: pool_subsys

sources:
  - common/pool_pkg.sv
  - hdl/pool_regs.sv
  - pool/pool_max_tree.sv
  - pool/pool_sequencer.sv
  - hdl/pool_subsys.sv
  - target: test
    files:
      - test/pool_model.sv
      - test/tb_pool_subsys.sv

//--- common/pool_pkg.sv
package pool_pkg;

    // pixel and stream widths
    localparam int PIX_W = 8;
    localparam int COL_W = 16;

    // register bus widths
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    typedef logic [PIX_W-1:0]     pix_t;
    typedef logic [COL_W-1:0]     col_cnt_t;    // column count or column index
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;    // word address
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // register map, word addresses
    localparam wb_addr_t ADDR_CTRL   = wb_addr_t'(0);
    localparam wb_addr_t ADDR_COL    = wb_addr_t'(1);
    localparam wb_addr_t ADDR_FRAMES = wb_addr_t'(2);   // read only

    // CTRL bit positions
    localparam int CTRL_POOL_EN = 0;
    localparam int CTRL_LAYER1  = 1;

    // sequencer states
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } seq_state_t;

endpackage

//--- hdl/pool_regs.sv
module pool_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  pool_pkg::wb_addr_t wb_adr,
    input  pool_pkg::wb_data_t wb_dat_w,
    output pool_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack,
    output logic               pool_en,
    output logic               layer1,
    output pool_pkg::col_cnt_t col,
    input  logic               frame_done
);
    import pool_pkg::*;

    logic     req;
    wb_data_t frames;
    wb_data_t rd_mux;

    // new request only when no ack is pending
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_comb
    begin
        rd_mux = '0;
        case (wb_adr)
            ADDR_CTRL:
            begin
                rd_mux[CTRL_POOL_EN] = pool_en;
                rd_mux[CTRL_LAYER1]  = layer1;
            end
            ADDR_COL:    rd_mux[COL_W-1:0] = col;
            ADDR_FRAMES: rd_mux = frames;
            default:     rd_mux = '0;     // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            pool_en  <= 1'b0;
            layer1   <= 1'b0;
            col      <= '0;
        end
        else
        begin
            wb_ack <= req;  // one cycle after stb
            if (req)
            begin
                if (wb_we)
                begin
                    case (wb_adr)
                        ADDR_CTRL:
                        begin
                            pool_en <= wb_dat_w[CTRL_POOL_EN];
                            layer1  <= wb_dat_w[CTRL_LAYER1];
                        end
                        ADDR_COL: col <= wb_dat_w[COL_W-1:0];
                        default:  ;   // frames and holes ignore writes
                    endcase
                end
                else
                begin
                    wb_dat_r <= rd_mux;
                end
            end
        end
    end

    // completed frames, either mode
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            frames <= '0;
        end
        else if (frame_done)
        begin
            frames <= frames + 32'd1;
        end
    end

    // a master that holds stb still sees a single ack per access
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

//--- hdl/pool_subsys.sv
module pool_subsys #(
    parameter int N_ROWS   = 24,
    parameter int N_OUT_L1 = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  pool_pkg::wb_addr_t             wb_adr,
    input  pool_pkg::wb_data_t             wb_dat_w,
    output pool_pkg::wb_data_t             wb_dat_r,
    output logic                           wb_ack,
    input  logic                           valid_in,
    input  pool_pkg::pix_t [N_ROWS-1:0]    data_in,
    output logic                           valid_out,
    output pool_pkg::pix_t [N_ROWS/2-1:0]  data_out,
    output logic                           pool_end
);
    import pool_pkg::*;

    logic                pool_en;
    logic                layer1;
    col_cnt_t            col;
    logic                frame_done;
    logic                stage_en;
    logic                col_odd;
    logic                col_last;
    pix_t [N_ROWS/2-1:0] pool_data;

    pool_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .pool_en    (pool_en),
        .layer1     (layer1),
        .col        (col),
        .frame_done (frame_done)
    );

    pool_sequencer #(
        .N_ROWS   (N_ROWS),
        .N_OUT_L1 (N_OUT_L1)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .data_in    (data_in),
        .pool_en    (pool_en),
        .layer1     (layer1),
        .col        (col),
        .pool_data  (pool_data),
        .stage_en   (stage_en),
        .col_odd    (col_odd),
        .col_last   (col_last),
        .valid_out  (valid_out),
        .pool_end   (pool_end),
        .frame_done (frame_done),
        .data_out   (data_out)
    );

    pool_max_tree #(
        .N_ROWS (N_ROWS)
    ) u_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .stage_en  (stage_en),
        .col_odd   (col_odd),
        .col_last  (col_last),
        .pool_data (pool_data)
    );

endmodule

//--- pool/pool_max_tree.sv
module pool_max_tree #(
    parameter int N_ROWS = 24
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  pool_pkg::pix_t [N_ROWS-1:0]      data_in,
    input  logic                             stage_en,
    input  logic                             col_odd,
    input  logic                             col_last,
    output pool_pkg::pix_t [N_ROWS/2-1:0]    pool_data
);
    import pool_pkg::*;

    localparam int N_OUT = N_ROWS / 2;

    pix_t [N_ROWS-1:0] col_q;   // accepted column
    pix_t [N_OUT-1:0]  vmax_q;  // stage 1, row pair max
    pix_t [N_OUT-1:0]  prev_q;  // stage 1 result of the previous column
    pix_t [N_OUT-1:0]  hmax_q;  // stage 2, column pair max
    logic              s1_en;
    logic              s1_odd;
    logic              s1_last;

    function automatic pix_t pix_max(input pix_t a, input pix_t b);
        return (a < b) ? b : a;
    endfunction

    // column capture, flags from the sequencer line up with this register
    always_ff @(posedge clk)
    begin
        col_q <= data_in;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            vmax_q  <= '0;
            s1_en   <= 1'b0;
            s1_odd  <= 1'b0;
            s1_last <= 1'b0;
        end
        else
        begin
            s1_en   <= stage_en;
            s1_odd  <= col_odd;
            s1_last <= col_last;
            if (stage_en)
            begin
                for (int i = 0; i < N_OUT; i++)
                begin
                    vmax_q[i] <= pix_max(col_q[2*i], col_q[2*i+1]);
                end
            end
            else
            begin
                vmax_q <= '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prev_q <= '0;
            hmax_q <= '0;
        end
        else if (s1_en)
        begin
            prev_q <= vmax_q;
            if (s1_odd)
            begin
                for (int i = 0; i < N_OUT; i++)
                begin
                    hmax_q[i] <= pix_max(vmax_q[i], prev_q[i]);
                end
            end
            else if (s1_last)
            begin
                hmax_q <= vmax_q;   // even last column has no partner
            end
        end
        else
        begin
            prev_q <= '0;
            hmax_q <= '0;
        end
    end

    assign pool_data = hmax_q;

endmodule

//--- pool/pool_sequencer.sv
module pool_sequencer #(
    parameter int N_ROWS   = 24,
    parameter int N_OUT_L1 = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid_in,
    input  pool_pkg::pix_t [N_ROWS-1:0]    data_in,
    input  logic                           pool_en,
    input  logic                           layer1,
    input  pool_pkg::col_cnt_t             col,
    input  pool_pkg::pix_t [N_ROWS/2-1:0]  pool_data,
    output logic                           stage_en,
    output logic                           col_odd,
    output logic                           col_last,
    output logic                           valid_out,
    output logic                           pool_end,
    output logic                           frame_done,
    output pool_pkg::pix_t [N_ROWS/2-1:0]  data_out
);
    import pool_pkg::*;

    localparam int N_OUT = N_ROWS / 2;

    seq_state_t       state;
    col_cnt_t         col_idx;
    logic             valid_prev;
    logic             accept;
    logic             idx_last;
    logic             fire_d1;
    logic             fire_d2;
    logic             end_d1;
    logic             end_d2;
    logic             byp_end;
    pix_t [N_OUT-1:0] pool_masked;

    // a frame starts only on a rising valid edge
    assign accept   = valid_in && ((state == RUN) || !valid_prev);
    assign idx_last = (col_idx == col - col_cnt_t'(1)) || (col == '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            col_idx <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (accept && !idx_last)
                    begin
                        state <= RUN;
                    end
                end
                RUN:
                begin
                    if (accept && idx_last)
                    begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (accept)
            begin
                col_idx <= idx_last ? '0 : col_idx + col_cnt_t'(1);
            end
        end
    end

    // flags for the tree, aligned with its column register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            stage_en   <= 1'b0;
            col_odd    <= 1'b0;
            col_last   <= 1'b0;
            valid_prev <= 1'b0;
            byp_end    <= 1'b0;
            fire_d1    <= 1'b0;
            fire_d2    <= 1'b0;
            end_d1     <= 1'b0;
            end_d2     <= 1'b0;
        end
        else
        begin
            stage_en   <= accept && pool_en;
            col_odd    <= col_idx[0];
            col_last   <= idx_last;
            valid_prev <= valid_in;
            byp_end    <= !valid_in && valid_prev;  // cycle after first idle beat
            // follow the tree's two stages
            fire_d1    <= stage_en && (col_odd || col_last);
            fire_d2    <= fire_d1;
            end_d1     <= stage_en && col_last;
            end_d2     <= end_d1;
        end
    end

    // narrow layer keeps only the low pixels
    always_comb
    begin
        for (int i = 0; i < N_OUT; i++)
        begin
            pool_masked[i] = (layer1 || (i < N_OUT_L1)) ? pool_data[i] : '0;
        end
    end

    assign data_out   = pool_en ? pool_masked : data_in[N_OUT-1:0]; // bypass keeps low half
    assign valid_out  = pool_en ? fire_d2 : valid_in;
    assign pool_end   = pool_en ? end_d2 : byp_end;
    assign frame_done = pool_end;

    // the end pulse always rides on the last pooled result
    a_end_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (pool_en && pool_end) |-> valid_out);

endmodule

//--- pool_subsys.f
common/pool_pkg.sv
hdl/pool_regs.sv
pool/pool_max_tree.sv
pool/pool_sequencer.sv
hdl/pool_subsys.sv
test/pool_model.sv
test/tb_pool_subsys.sv

//--- test/pool_model.sv
package pool_model;
    import pool_pkg::*;

    localparam int N_ROWS   = 24;
    localparam int N_OUT    = N_ROWS / 2;
    localparam int N_OUT_L1 = 6;

    typedef pix_t [N_ROWS-1:0] column_t;
    typedef pix_t [N_OUT-1:0]  result_t;

    // 2x2 max of columns a and b, or row pairs of a alone
    function automatic result_t pool_block(input column_t a, input column_t b,
                                           input bit has_b, input bit layer1);
        result_t r;
        pix_t    m;
        for (int i = 0; i < N_OUT; i++)
        begin
            m = (a[2*i] > a[2*i+1]) ? a[2*i] : a[2*i+1];
            if (has_b && (b[2*i] > m))
            begin
                m = b[2*i];
            end
            if (has_b && (b[2*i+1] > m))
            begin
                m = b[2*i+1];
            end
            r[i] = (layer1 || (i < N_OUT_L1)) ? m : pix_t'(0);  // narrow layer
        end
        return r;
    endfunction

    // bypass shows the low half of the column
    function automatic result_t bypass_data(input column_t c);
        return c[N_OUT-1:0];
    endfunction

    // end pulse one cycle after the first idle beat
    function automatic bit bypass_end(input bit valid_d1, input bit valid_d2);
        return valid_d2 && !valid_d1;
    endfunction

    // one result per column pair, a lone last column counts too
    function automatic int num_outputs(input int ncol);
        return (ncol + 1) / 2;
    endfunction

endpackage

//--- test/tb_pool_subsys.sv
module tb_pool_subsys;
    timeunit 1ns;
    timeprecision 1ps;
    import pool_pkg::*;
    import pool_model::*;

    localparam int SEED         = 96990;
    localparam int DRIVE_DLY    = 5;
    localparam int MAX_COL      = 40;
    localparam int IDLE_GAP     = 6;
    localparam int ACK_LIMIT    = 16;
    localparam int N_FRAMES_MAX = 21;   // four runs of four plus up to five mixed
    localparam int WATCHDOG_CYCLES = N_FRAMES_MAX * (MAX_COL + 8) + 1500;

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     valid_in;
    column_t  data_in;
    logic     valid_out;
    result_t  data_out;
    logic     pool_end;

    bit       pooled_mode;
    bit       layer1_mode;
    logic     v_hist1;      // valid_in one and two cycles back
    logic     v_hist2;
    int       checks;
    int       errors;
    int       frames_sent;
    int       out_count;
    string    test_name;
    result_t  exp_data[$];
    bit       exp_end[$];

    pool_subsys #(
        .N_ROWS   (N_ROWS),
        .N_OUT_L1 (N_OUT_L1)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .pool_end  (pool_end)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("ERR %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
        end
    endtask

    function automatic column_t random_column();
        column_t c;
        for (int r = 0; r < N_ROWS; r++)
        begin
            c[r] = pix_t'($urandom);
        end
        return c;
    endfunction

    // one classic cycle with the ack on the next edge
    task automatic wb_access(input bit write, input wb_addr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        int acks;
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = addr;
        wb_dat_w = wdata;
        waited   = 0;
        acks     = 0;
        rdata    = '0;
        while ((acks == 0) && (waited < ACK_LIMIT))
        begin
            @(posedge clk);
            waited++;
            @(negedge clk);     // look mid cycle
            if (wb_ack)
            begin
                acks++;
                rdata = wb_dat_r;
            end
        end
        if (acks == 0)
        begin
            errors++;
            $display("wishbone access to address %0d was never acknowledged", addr);
        end
        check_value("ack latency", 1, waited);
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        if (wb_ack)
        begin
            acks++;
        end
        check_value("ack count", 1, acks);
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic set_ctrl(input wb_data_t word);
        wb_write(ADDR_CTRL, word);
        pooled_mode = word[CTRL_POOL_EN];
        layer1_mode = word[CTRL_LAYER1];
    endtask

    // expected results go in first, then the columns are streamed
    task automatic send_frame(input int ncol);
        column_t cols[];
        int      start_count;
        int      waited;
        cols = new[ncol];
        foreach (cols[c])
        begin
            cols[c] = random_column();
        end
        if (pooled_mode)
        begin
            for (int k = 0; k < ncol; k += 2)
            begin
                exp_data.push_back(pool_block(cols[k], cols[(k+1) % ncol], (k + 1) < ncol,
                                              layer1_mode));
                exp_end.push_back((k + 2) >= ncol);
            end
        end
        start_count = out_count;
        for (int c = 0; c < ncol; c++)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            valid_in = 1'b1;
            data_in  = cols[c];
        end
        @(posedge clk);
        #DRIVE_DLY;
        valid_in = 1'b0;
        data_in  = random_column();     // idle junk
        repeat (IDLE_GAP - 1) @(posedge clk);
        waited = 0;
        while ((exp_data.size() > 0) && (waited < 32))
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_data.size() > 0)
        begin
            errors++;
            $display("%s: %0d pooled results never came out", test_name, exp_data.size());
            exp_data.delete();
            exp_end.delete();
        end
        if (pooled_mode)
        begin
            check_value("output count", num_outputs(ncol), out_count - start_count);
        end
        frames_sent++;
    endtask

    // kind 0 even columns, 1 odd columns, else any
    task automatic run_frames(input string name, input int count, input bit en,
                              input bit l1, input int kind);
        int ncol;
        test_name = name;
        set_ctrl({30'b0, l1, en});
        repeat (count)
        begin
            case (kind)
                0:       ncol = 2 + 2 * ($urandom % (MAX_COL / 2));
                1:       ncol = 1 + 2 * ($urandom % (MAX_COL / 2));
                default: ncol = 1 + ($urandom % MAX_COL);
            endcase
            wb_write(ADDR_COL, ncol);
            send_frame(ncol);
        end
    endtask

    always @(negedge clk)
    begin : output_check
        result_t expected;
        bit      expected_end;
        if (rst_n)
        begin
            if (pooled_mode && (valid_out || pool_end))
            begin
                if (exp_data.size() == 0)
                begin
                    errors++;
                    $display("%s: pooled output with no result pending", test_name);
                end
                else
                begin
                    expected     = exp_data.pop_front();
                    expected_end = exp_end.pop_front();
                    check_value("valid_out", 1, valid_out);
                    check_value("data_out", expected, data_out);
                    check_value("pool_end", expected_end, pool_end);
                    out_count++;
                end
            end
            else if (!pooled_mode)
            begin
                check_value("bypass valid_out", valid_in, valid_out);
                if (valid_in)
                begin
                    check_value("bypass data_out", bypass_data(data_in), data_out);
                end
                check_value("bypass pool_end", bypass_end(v_hist1, v_hist2), pool_end);
            end
            v_hist2 = v_hist1;
            v_hist1 = valid_in;
        end
    end

    initial
    begin : main
        int       n;
        wb_data_t wdata;
        wb_data_t rdata;
        wb_addr_t addr;
        void'($urandom(SEED));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        valid_in = 1'b0;
        data_in  = random_column();
        v_hist1  = 1'b0;
        v_hist2  = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        test_name = "register access";
        repeat (8)
        begin
            wdata = $urandom;
            set_ctrl(wdata);
            wb_read(ADDR_CTRL, rdata);
            check_value("ctrl readback", wdata & 32'h3, rdata);
            wdata = $urandom;
            wb_write(ADDR_COL, wdata);
            wb_read(ADDR_COL, rdata);
            check_value("col readback", wdata & 32'hffff, rdata);
            addr = wb_addr_t'(3 + ($urandom % 13));
            wb_write(addr, $urandom);
            wb_read(addr, rdata);
            check_value("unmapped read", 0, rdata);
            wb_write(ADDR_FRAMES, $urandom);    // read only
            wb_read(ADDR_FRAMES, rdata);
            check_value("frames unchanged", 0, rdata);
        end

        run_frames("pooled even", 4, 1'b1, 1'b1, 0);
        run_frames("pooled odd", 4, 1'b1, 1'b1, 1);
        run_frames("layer1 clear", 4, 1'b1, 1'b0, 2);
        run_frames("bypass", 4, 1'b0, 1'($urandom), 2);

        test_name = "frame counter";
        wb_read(ADDR_FRAMES, rdata);
        check_value("frames", frames_sent, rdata);
        n = 2 + ($urandom % 4);
        repeat (n)
        begin
            run_frames("mixed frames", 1, 1'($urandom), 1'($urandom), 2);
        end
        test_name = "frame counter";
        wb_read(ADDR_FRAMES, rdata);
        check_value("frames", frames_sent, rdata);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks %0d errors %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

endmodule
